// File: logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and register file sizes
`define CORE_XLEN      32
`define CORE_NREGS     32
`define CORE_REG_BITS  5

// major opcodes, bits [6:0]
`define CORE_OP_REG     7'b0110011   // R-type alu
`define CORE_OP_IMM     7'b0010011   // I-type alu
`define CORE_OP_SYSTEM  7'b1110011
`define CORE_INST_WFI   32'h10500073 // full word, only legal system op

// funct3 / funct7 alu selects
`define CORE_F3_ADD_SUB 3'b000       // also addi
`define CORE_F3_XOR     3'b100
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111
`define CORE_F7_BASE    7'b0000000
`define CORE_F7_SUB     7'b0100000

`endif

// File: logic/core_pkg.sv
`default_nettype none
`include "core_defines.svh"

package core_pkg;

	//////////////////////////////////////////////////////////////////////
	// plain vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [`CORE_XLEN-1:0]     data_t;    // register value
	typedef logic [`CORE_REG_BITS-1:0] reg_idx_t; // x0..x31
	typedef logic [31:0]               inst_t;    // raw instruction word
	typedef logic [11:0]               imm12_t;   // I-type immediate field

	//////////////////////////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4
	} alu_op_t;

	// what writeback does with an item
	typedef enum logic [1:0] {
		KIND_ALU     = 2'd0, // write rd
		KIND_HALT    = 2'd1, // wfi
		KIND_ILLEGAL = 2'd2  // anything not decoded
	} inst_kind_t;

	typedef enum logic [1:0] {
		STATUS_RUN     = 2'd0,
		STATUS_HALTED  = 2'd1,
		STATUS_ILLEGAL = 2'd2
	} status_t;

endpackage

`default_nettype wire

// File: logic/core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decode register contents, decode -> execute
interface decoded_if;
	import core_pkg::*;

	logic       valid;   // low for a bubble
	inst_kind_t kind;
	alu_op_t    alu_op;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	data_t      imm;     // already sign extended
	logic       use_imm; // operand b from imm, not rs2
	reg_idx_t   rd;

	modport producer (output valid, kind, alu_op, rs1, rs2, imm, use_imm, rd);
	modport consumer (input valid, kind, alu_op, rs1, rs2, imm, use_imm, rd);
endinterface

// execute result register, execute -> writeback
interface result_if;
	import core_pkg::*;

	logic       valid;
	inst_kind_t kind;
	reg_idx_t   rd;
	data_t      value;

	modport producer (output valid, kind, rd, value);
	modport consumer (input valid, kind, rd, value);
endinterface

// async register file read, indices out and data back same cycle
interface reg_read_if;
	import core_pkg::*;

	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	data_t    rs1_data;
	data_t    rs2_data;

	modport requester (output rs1_idx, rs2_idx, input rs1_data, rs2_data);
	modport provider (input rs1_idx, rs2_idx, output rs1_data, rs2_data);
endinterface

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module decode_stage (
	input  logic            clock,
	input  logic            reset,
	input  logic            in_valid,
	input  core_pkg::inst_t in_inst,
	input  logic            running,  // doubles as in_ready
	decoded_if.producer     dec
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	imm12_t     imm_raw;

	inst_kind_t kind_next;
	alu_op_t    op_next;
	logic       use_imm_next;

	//////////////////////////////////////////////////////////////////////
	// field split and classify
	//////////////////////////////////////////////////////////////////////

	assign opcode  = in_inst[6:0];
	assign funct3  = in_inst[14:12];
	assign funct7  = in_inst[31:25];
	assign imm_raw = in_inst[31:20];

	always_comb begin
		kind_next    = KIND_ILLEGAL; // default unless matched
		op_next      = ALU_ADD;
		use_imm_next = 1'b0;
		case (opcode)
			`CORE_OP_REG: begin
				if (funct7 == `CORE_F7_BASE) begin
					kind_next = KIND_ALU;
					case (funct3)
						`CORE_F3_ADD_SUB: op_next = ALU_ADD;
						`CORE_F3_XOR:     op_next = ALU_XOR;
						`CORE_F3_OR:      op_next = ALU_OR;
						`CORE_F3_AND:     op_next = ALU_AND;
						default:          kind_next = KIND_ILLEGAL; // slt, shifts
					endcase
				end else if (funct7 == `CORE_F7_SUB && funct3 == `CORE_F3_ADD_SUB) begin
					kind_next = KIND_ALU;
					op_next   = ALU_SUB;
				end
			end
			`CORE_OP_IMM: begin
				// only addi
				if (funct3 == `CORE_F3_ADD_SUB) begin
					kind_next    = KIND_ALU;
					use_imm_next = 1'b1;
				end
			end
			`CORE_OP_SYSTEM: begin
				if (in_inst == `CORE_INST_WFI)
					kind_next = KIND_HALT;
			end
			default: kind_next = KIND_ILLEGAL;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// decode register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= in_valid && running; // idle or stopped -> bubble
		end
	end

	// payload, only meaningful with valid
	always_ff @(posedge clock) begin
		dec.kind    <= kind_next;
		dec.alu_op  <= op_next;
		dec.rs1     <= in_inst[19:15];
		dec.rs2     <= in_inst[24:20];   // don't care for addi
		dec.rd      <= in_inst[11:7];
		dec.imm     <= {{(`CORE_XLEN-12){imm_raw[11]}}, imm_raw}; // sign extend
		dec.use_imm <= use_imm_next;
	end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic          clock,
	input  logic          reset,
	decoded_if.consumer   dec,
	reg_read_if.requester rf,
	result_if.producer    res
);
	import core_pkg::*;

	logic  fwd_ok;  // result register holds a forwardable write
	logic  fwd_rs1;
	logic  fwd_rs2;
	data_t op_a;
	data_t rs2_val;
	data_t op_b;
	data_t alu_out;

	//////////////////////////////////////////////////////////////////////
	// operands
	//////////////////////////////////////////////////////////////////////

	assign rf.rs1_idx = dec.rs1;
	assign rf.rs2_idx = dec.rs2;

	// two-ahead is already in the regfile, one-ahead sits in res
	assign fwd_ok  = res.valid && (res.kind == KIND_ALU) && (res.rd != '0);
	assign fwd_rs1 = fwd_ok && (res.rd == dec.rs1);
	assign fwd_rs2 = fwd_ok && (res.rd == dec.rs2);

	assign op_a    = fwd_rs1 ? res.value : rf.rs1_data;
	assign rs2_val = fwd_rs2 ? res.value : rf.rs2_data;
	assign op_b    = dec.use_imm ? dec.imm : rs2_val; // addi

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (dec.alu_op)
			ALU_ADD: alu_out = op_a + op_b;
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			ALU_XOR: alu_out = op_a ^ op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// result register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset) begin
			res.valid <= 1'b0;
		end else begin
			res.valid <= dec.valid; // nothing stalls, bubbles pass through
		end
	end

	always_ff @(posedge clock) begin
		res.kind  <= dec.kind;
		res.rd    <= dec.rd;
		res.value <= alu_out; // garbage for halt/illegal, never written
	end

endmodule

`default_nettype wire

// File: logic/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module writeback_stage (
	input  logic               clock,
	input  logic               reset,
	result_if.consumer         res,
	reg_read_if.provider       rf,
	output logic               running,
	output logic               commit_valid,
	output logic               commit_wr_en,
	output core_pkg::reg_idx_t commit_wr_idx,
	output core_pkg::data_t    commit_wr_data,
	output core_pkg::status_t  status
);
	import core_pkg::*;

	data_t regs [0:`CORE_NREGS-1];
	logic  take;     // item commits this edge
	logic  do_write; // and it updates rd

	//////////////////////////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////////////////////////

	// x0 is hardwired, regs[0] never written
	assign rf.rs1_data = (rf.rs1_idx == '0) ? '0 : regs[rf.rs1_idx];
	assign rf.rs2_data = (rf.rs2_idx == '0) ? '0 : regs[rf.rs2_idx];

	assign running  = (status == STATUS_RUN);
	assign take     = res.valid && running; // after a stop, everything younger is dropped
	assign do_write = take && (res.kind == KIND_ALU) && (res.rd != '0);

	always_ff @(posedge clock) begin
		if (do_write)
			regs[res.rd] <= res.value;
	end

	//////////////////////////////////////////////////////////////////////
	// commit outputs and status
	//////////////////////////////////////////////////////////////////////

	// commit payload mirrors the write port
	always_ff @(posedge clock) begin
		commit_wr_idx  <= res.rd;
		commit_wr_data <= res.value;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			commit_valid <= 1'b0;
			commit_wr_en <= 1'b0;
			status       <= STATUS_RUN;
		end else begin
			commit_valid <= take;
			commit_wr_en <= do_write;   // low for x0, halt, illegal
			if (take) begin
				// status moves with the commit of the stopping item
				case (res.kind)
					KIND_HALT:    status <= STATUS_HALTED;
					KIND_ILLEGAL: status <= STATUS_ILLEGAL;
					default:      status <= STATUS_RUN;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic               clock,
	input  logic               reset,
	input  logic               in_valid,
	input  core_pkg::inst_t    in_inst,
	output logic               in_ready,      // high while status is run
	output logic               commit_valid,
	output logic               commit_wr_en,
	output core_pkg::reg_idx_t commit_wr_idx,
	output core_pkg::data_t    commit_wr_data,
	output core_pkg::status_t  status
);

	//////////////////////////////////////////////////////////////////////
	// stage links
	//////////////////////////////////////////////////////////////////////

	decoded_if  dec_link ();  // decode reg -> execute
	result_if   res_link ();  // result reg -> writeback
	reg_read_if rf_link ();   // execute <-> regfile

	decode_stage i_decode (
		.clock    (clock),
		.reset    (reset),
		.in_valid (in_valid),
		.in_inst  (in_inst),
		.running  (in_ready),
		.dec      (dec_link.producer)
	);

	execute_stage i_execute (
		.clock (clock),
		.reset (reset),
		.dec   (dec_link.consumer),
		.rf    (rf_link.requester),
		.res   (res_link.producer)
	);

	writeback_stage i_writeback (
		.clock          (clock),
		.reset          (reset),
		.res            (res_link.consumer),
		.rf             (rf_link.provider),
		.running        (in_ready),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.status         (status)
	);

endmodule

`default_nettype wire

// File: test/core_props.sv
`timescale 1ns/1ps
`default_nettype none

module core_props (
	input logic              clock,
	input logic              reset,
	input logic              in_ready,
	input logic              commit_valid,
	input logic              commit_wr_en,
	input core_pkg::status_t status
);
	import core_pkg::*;

	int fail_count = 0; // failed assertions so far

	// commit register cleared by reset
	commit_clear: assert property (@(posedge clock) !reset |=> !commit_valid)
		else begin fail_count++; $error("commit_valid high after reset"); end

	write_needs_commit: assert property (@(posedge clock) disable iff (!reset)
		commit_wr_en |-> commit_valid)
		else begin fail_count++; $error("commit_wr_en without commit_valid"); end

	ready_is_running: assert property (@(posedge clock) disable iff (!reset)
		in_ready == (status == STATUS_RUN))
		else begin fail_count++; $error("in_ready does not track status"); end

	// a stop is permanent until reset
	stop_sticks: assert property (@(posedge clock) disable iff (!reset)
		(status != STATUS_RUN) |=> (status != STATUS_RUN))
		else begin fail_count++; $error("status returned to run"); end

endmodule

bind core_top core_props i_props (
	.clock        (clock),
	.reset        (reset),
	.in_ready     (in_ready),
	.commit_valid (commit_valid),
	.commit_wr_en (commit_wr_en),
	.status       (status)
);

`default_nettype wire

// File: test/core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module core_tb;
	import core_pkg::*;

	// one expected commit
	typedef struct packed {
		logic       wr_en;
		reg_idx_t   idx;
		data_t      data;
		inst_kind_t kind;
	} expect_t;

	logic     clock;
	logic     reset;
	logic     in_valid;
	inst_t    in_inst;
	logic     in_ready;
	logic     commit_valid;
	logic     commit_wr_en;
	reg_idx_t commit_wr_idx;
	data_t    commit_wr_data;
	status_t  status;

	integer   seed = 59;
	string    test_name = "reset";
	int       edge_count = 0;            // rising edges seen
	expect_t  exp_q [$];
	int       due_q [$];                 // edge count at which each commit shows
	data_t    model_regs [0:`CORE_NREGS-1];
	logic     model_stopped = 1'b0;      // halt or illegal already accepted
	logic     exp_ready = 1'b1;          // low once the stop item has committed
	reg_idx_t rd;
	reg_idx_t prev1;
	reg_idx_t prev2;
	logic [31:0] rnd;

	core_top i_dut (
		.clock          (clock),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_inst        (in_inst),
		.in_ready       (in_ready),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.status         (status)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) edge_count <= edge_count + 1;

	//////////////////////////////////////////////////////////////////////
	// reference model and encoders
	//////////////////////////////////////////////////////////////////////

	function automatic expect_t ref_execute(input inst_t w, input data_t regs [0:`CORE_NREGS-1]);
		expect_t e;
		data_t   a;
		data_t   b;
		a = (w[19:15] == 5'd0) ? '0 : regs[w[19:15]];
		b = (w[24:20] == 5'd0) ? '0 : regs[w[24:20]];
		e.kind = KIND_ILLEGAL;
		e.idx  = w[11:7];
		e.data = '0;
		if (w[6:0] == `CORE_OP_REG) begin
			e.kind = KIND_ALU;
			case ({w[31:25], w[14:12]})
				{`CORE_F7_BASE, `CORE_F3_ADD_SUB}: e.data = a + b;
				{`CORE_F7_SUB, `CORE_F3_ADD_SUB}:  e.data = a - b;
				{`CORE_F7_BASE, `CORE_F3_AND}:     e.data = a & b;
				{`CORE_F7_BASE, `CORE_F3_OR}:      e.data = a | b;
				{`CORE_F7_BASE, `CORE_F3_XOR}:     e.data = a ^ b;
				default:                           e.kind = KIND_ILLEGAL;
			endcase
		end else if (w[6:0] == `CORE_OP_IMM && w[14:12] == `CORE_F3_ADD_SUB) begin
			e.kind = KIND_ALU;
			e.data = a + {{20{w[31]}}, w[31:20]}; // addi, sign extended
		end else if (w == `CORE_INST_WFI) begin
			e.kind = KIND_HALT;
		end
		e.wr_en = (e.kind == KIND_ALU) && (e.idx != 5'd0);
		return e;
	endfunction

	function automatic inst_t r_word(input logic [6:0] f7, input logic [2:0] f3,
			input reg_idx_t d, input reg_idx_t s1, input reg_idx_t s2);
		return {f7, s2, s1, f3, d, `CORE_OP_REG};
	endfunction

	function automatic inst_t addi_word(input reg_idx_t d, input reg_idx_t s1,
			input logic [11:0] imm);
		return {imm, s1, `CORE_F3_ADD_SUB, d, `CORE_OP_IMM};
	endfunction

	// one of add, sub, and, or, xor
	function automatic inst_t random_alu_word(input reg_idx_t d, input reg_idx_t s1,
			input reg_idx_t s2);
		logic [31:0] pick;
		pick = $random(seed);
		case (pick % 5)
			0:       return r_word(`CORE_F7_BASE, `CORE_F3_ADD_SUB, d, s1, s2);
			1:       return r_word(`CORE_F7_SUB, `CORE_F3_ADD_SUB, d, s1, s2);
			2:       return r_word(`CORE_F7_BASE, `CORE_F3_AND, d, s1, s2);
			3:       return r_word(`CORE_F7_BASE, `CORE_F3_OR, d, s1, s2);
			default: return r_word(`CORE_F7_BASE, `CORE_F3_XOR, d, s1, s2);
		endcase
	endfunction

	function automatic reg_idx_t random_reg(); // never x0
		logic [31:0] r;
		r = $random(seed);
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string what, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("ERROR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_idx(input string what, input reg_idx_t exp, input reg_idx_t act);
		if (exp !== act) begin
			$display("ERROR [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERROR [%s] %s: expected %b, actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_status(input string what, input status_t exp, input status_t act);
		if (exp !== act) begin
			$display("ERROR [%s] %s: expected %s, actual %s", test_name, what,
				exp.name(), act.name());
			abort_run();
		end
	endtask

	task automatic check_latency(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("ERROR [%s] %s: expected edge %0d, actual edge %0d", test_name, what,
				exp, act);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking process, sampled at the falling edge
	//////////////////////////////////////////////////////////////////////

	initial begin : compare_commits
		expect_t e;
		status_t exp_status;
		int      due;
		forever begin
			@(negedge clock);
			if (reset === 1'b1) begin
				if (commit_valid === 1'b1) begin
					if (exp_q.size() == 0) begin
						$display("[%s] a commit appeared with nothing outstanding", test_name);
						abort_run();
					end
					e   = exp_q.pop_front();
					due = due_q.pop_front();
					case (e.kind)
						KIND_HALT:    exp_status = STATUS_HALTED;
						KIND_ILLEGAL: exp_status = STATUS_ILLEGAL;
						default:      exp_status = STATUS_RUN;
					endcase
					check_latency("commit time", due, edge_count);
					check_bit("commit_wr_en", e.wr_en, commit_wr_en);
					if (e.kind == KIND_ALU) begin
						check_idx("commit_wr_idx", e.idx, commit_wr_idx);
						check_data("commit_wr_data", e.data, commit_wr_data);
					end
					check_status("status at commit", exp_status, status);
					if (e.kind != KIND_ALU)
						exp_ready = 1'b0; // stopped from this commit on
				end else if (commit_valid !== 1'b0) begin
					$display("[%s] commit_valid is unknown after reset", test_name);
					abort_run();
				end
				check_bit("in_ready", exp_ready, in_ready);
				if (i_dut.i_props.fail_count != 0) begin
					$display("[%s] a bound assertion failed", test_name);
					abort_run();
				end
				// word taken at the next edge, visible three edges on
				if ((in_valid === 1'b1) && !model_stopped) begin
					e = ref_execute(in_inst, model_regs);
					if (e.wr_en)
						model_regs[e.idx] = e.data;
					if (e.kind != KIND_ALU)
						model_stopped = 1'b1; // younger words are dropped
					exp_q.push_back(e);
					due_q.push_back(edge_count + 3);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		reset    = 1'b0;
		in_valid = 1'b0;
		repeat (4) @(posedge clock);
		#5;
		reset = 1'b1;
		exp_q.delete();
		due_q.delete();
		model_stopped = 1'b0;
		exp_ready     = 1'b1;
	endtask

	task automatic send(input inst_t w); // one word per cycle
		in_valid = 1'b1;
		in_inst  = w;
		@(posedge clock);
		#5;
		in_valid = 1'b0;
	endtask

	task automatic idle(input int cycles);
		in_valid = 1'b0;
		repeat (cycles) begin
			@(posedge clock);
			#5;
		end
	endtask

	task automatic drain();
		int waited = 0;
		while (exp_q.size() != 0 && waited < 40) begin
			@(posedge clock);
			#5;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("[%s] %0d instructions never committed", test_name, exp_q.size());
			abort_run();
		end
	endtask

	initial begin
		reset    = 1'b0;
		in_valid = 1'b0;
		in_inst  = '0;
		model_regs[0] = '0;
		apply_reset();
		check_bit("in_ready", 1'b1, in_ready);
		check_status("status", STATUS_RUN, status);
		idle(5);                               // checker flags any commit here

		test_name = "random alu";
		for (int r = 1; r < `CORE_NREGS; r++) begin
			rnd = $random(seed);
			send(addi_word(r[4:0], 5'd0, rnd[11:0]));
		end
		for (int i = 0; i < 40; i++)
			send(random_alu_word(random_reg(), random_reg(), random_reg()));
		drain();

		test_name = "addi negative with gaps";
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			send(addi_word(random_reg(), random_reg(), {1'b1, rnd[10:0]}));
			idle(rnd[13:12]);                  // 0 to 3 idle cycles
		end
		drain();

		test_name = "forwarding";
		prev1 = 5'd1;
		prev2 = 5'd2;
		for (int i = 0; i < 24; i++) begin
			rd = random_reg();
			rnd = $random(seed);
			if (i % 3 == 2)
				send(addi_word(rd, prev1, rnd[11:0]));
			else
				send(random_alu_word(rd, prev1, prev2)); // distance one and two
			prev2 = prev1;
			prev1 = rd;
		end
		drain();

		test_name = "x0 writes";
		send(r_word(`CORE_F7_BASE, `CORE_F3_ADD_SUB, 5'd0, 5'd1, 5'd2));
		send(r_word(`CORE_F7_BASE, `CORE_F3_OR, 5'd4, 5'd0, 5'd3));  // x0 not forwarded
		send(addi_word(5'd5, 5'd0, 12'h7ff));
		send(r_word(`CORE_F7_BASE, `CORE_F3_ADD_SUB, 5'd6, 5'd0, 5'd0));
		drain();

		test_name = "wfi halt";
		send(random_alu_word(random_reg(), random_reg(), random_reg()));
		send(`CORE_INST_WFI);
		for (int i = 0; i < 3; i++)
			send(random_alu_word(random_reg(), random_reg(), random_reg()));
		drain();
		idle(6);                               // dropped words must not show
		check_status("status after wfi", STATUS_HALTED, status);
		check_bit("in_ready after wfi", 1'b0, in_ready);

		test_name = "illegal word";
		apply_reset();
		check_status("status after reset", STATUS_RUN, status);
		send(random_alu_word(random_reg(), random_reg(), random_reg()));
		send(r_word(`CORE_F7_BASE, 3'b001, 5'd7, 5'd1, 5'd2)); // sll, not supported
		for (int i = 0; i < 3; i++)
			send(random_alu_word(random_reg(), random_reg(), random_reg()));
		drain();
		idle(6);
		check_status("status after illegal", STATUS_ILLEGAL, status);
		check_bit("in_ready after illegal", 1'b0, in_ready);

		if (i_dut.i_props.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/core_pkg.sv
logic/core_ifs.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/core_top.sv
test/core_props.sv
test/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := core_tb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert
LOG       := sim.log
PASS_MSG  := all tests passed
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
